/* include/calendar_params.svh */
`ifndef CALENDAR_PARAMS_SVH
`define CALENDAR_PARAMS_SVH

`define CAL_FIELDS 6

// field codes of the selector switch where 0 and 7..15 select nothing
`define CAL_CODE_SEC   4'd1
`define CAL_CODE_MIN   4'd2
`define CAL_CODE_HOUR  4'd3
`define CAL_CODE_YEAR  4'd4
`define CAL_CODE_MONTH 4'd5
`define CAL_CODE_DAY   4'd6

`define CAL_LOW_SEC    0
`define CAL_HIGH_SEC   59
`define CAL_LOW_MIN    0
`define CAL_HIGH_MIN   59
`define CAL_LOW_HOUR   0
`define CAL_HIGH_HOUR  23
`define CAL_LOW_YEAR   0
`define CAL_HIGH_YEAR  99
`define CAL_LOW_MONTH  1
`define CAL_HIGH_MONTH 12
`define CAL_LOW_DAY    1
`define CAL_HIGH_DAY   31

// field index k belongs to field code k + 1
`define CAL_LIMIT_LOW(k) \
	((k) == 0 ? `CAL_LOW_SEC : \
	(k) == 1 ? `CAL_LOW_MIN : \
	(k) == 2 ? `CAL_LOW_HOUR : \
	(k) == 3 ? `CAL_LOW_YEAR : \
	(k) == 4 ? `CAL_LOW_MONTH : \
	`CAL_LOW_DAY)

`define CAL_LIMIT_HIGH(k) \
	((k) == 0 ? `CAL_HIGH_SEC : \
	(k) == 1 ? `CAL_HIGH_MIN : \
	(k) == 2 ? `CAL_HIGH_HOUR : \
	(k) == 3 ? `CAL_HIGH_YEAR : \
	(k) == 4 ? `CAL_HIGH_MONTH : \
	`CAL_HIGH_DAY)

`define CAL_SYNC_STAGES 2

`endif

/* hw/calendar_pkg.sv */
`include "calendar_params.svh"

package calendar_pkg;

typedef struct packed {
	logic [`CAL_FIELDS-1:0] up;   // one-hot per field and one cycle wide
	logic [`CAL_FIELDS-1:0] down;
} adjust_cmd_t;

typedef struct packed {
	logic [3:0] tens;
	logic [3:0] units;
} bcd_pair_t;

typedef struct packed {
	logic [6:0] bin;
	bcd_pair_t bcd;
} field_value_t;

// display order puts the year in the top byte
typedef struct packed {
	bcd_pair_t year;
	bcd_pair_t month;
	bcd_pair_t day;
	bcd_pair_t hour;
	bcd_pair_t minute;
	bcd_pair_t second;
} date_time_t;

// shift-and-add-3 conversion that is only valid for inputs below 100
function automatic bcd_pair_t to_bcd(input logic [6:0] bin);
	logic [14:0] work;
	int i;
	work = {8'd0, bin};
	for (i = 0; i < 7; i++) begin
		if (work[10:7] > 4'd4) begin
			work[10:7] = work[10:7] + 4'd3;
		end
		if (work[14:11] > 4'd4) begin
			work[14:11] = work[14:11] + 4'd3;
		end
		work = work << 1;
	end
	return bcd_pair_t'(work[14:7]);
endfunction

endpackage

/* hw/adjust_decoder.sv */
`timescale 1ns/100ps
`include "calendar_params.svh"

module adjust_decoder (
	input logic clk,
	input logic reset,
	input logic [3:0] field_code,
	input logic btn_up,
	input logic btn_down,
	output calendar_pkg::adjust_cmd_t cmd
);

logic [`CAL_SYNC_STAGES-1:0] up_sync;
logic [`CAL_SYNC_STAGES-1:0] down_sync;
logic up_last;
logic down_last;
logic up_edge;
logic down_edge;
logic [`CAL_FIELDS-1:0] field_onehot;
calendar_pkg::adjust_cmd_t cmd_next;

assign up_edge = up_sync[`CAL_SYNC_STAGES-1] & ~up_last;
assign down_edge = down_sync[`CAL_SYNC_STAGES-1] & ~down_last;

always_comb begin
	field_onehot = '0;
	case (field_code)
		`CAL_CODE_SEC: field_onehot[`CAL_CODE_SEC - 1] = 1'b1;
		`CAL_CODE_MIN: field_onehot[`CAL_CODE_MIN - 1] = 1'b1;
		`CAL_CODE_HOUR: field_onehot[`CAL_CODE_HOUR - 1] = 1'b1;
		`CAL_CODE_YEAR: field_onehot[`CAL_CODE_YEAR - 1] = 1'b1;
		`CAL_CODE_MONTH: field_onehot[`CAL_CODE_MONTH - 1] = 1'b1;
		`CAL_CODE_DAY: field_onehot[`CAL_CODE_DAY - 1] = 1'b1;
		default: field_onehot = '0;  // unused codes drop the press
	endcase
end

// a simultaneous press counts as up
always_comb begin
	cmd_next = '0;
	if (up_edge) begin
		cmd_next.up = field_onehot;
	end else if (down_edge) begin
		cmd_next.down = field_onehot;
	end
end

always_ff @(posedge clk or posedge reset) begin
	if (reset) begin
		up_sync <= '0;
		down_sync <= '0;
		up_last <= 1'b0;
		down_last <= 1'b0;
		cmd <= '0;
	end else begin
		up_sync <= {up_sync[`CAL_SYNC_STAGES-2:0], btn_up};
		down_sync <= {down_sync[`CAL_SYNC_STAGES-2:0], btn_down};
		up_last <= up_sync[`CAL_SYNC_STAGES-1];  // held buttons give no further edges
		down_last <= down_sync[`CAL_SYNC_STAGES-1];
		cmd <= cmd_next;
	end
end

endmodule

/* hw/field_counter.sv */
`timescale 1ns/100ps

module field_counter #(
	parameter int LOW = 0,
	parameter int HIGH = 59
) (
	input logic clk,
	input logic reset,
	input logic up,
	input logic down,
	output calendar_pkg::field_value_t value
);

logic [6:0] count_next;
logic at_high;
logic at_low;

assign at_high = value.bin >= 7'(HIGH);
assign at_low = value.bin == 7'(LOW);

always_comb begin
	count_next = value.bin;
	if (up) begin
		if (at_high) begin
			count_next = 7'(LOW);
		end else begin
			count_next = value.bin + 7'd1;
		end
	end else if (down) begin
		if (at_low) begin
			count_next = 7'(HIGH);
		end else begin
			count_next = value.bin - 7'd1;
		end
	end
end

// the digits are registered with the count so the two never disagree
always_ff @(posedge clk or posedge reset) begin
	if (reset) begin
		value.bin <= 7'(LOW);
		value.bcd <= calendar_pkg::to_bcd(7'(LOW));
	end else if (up || down) begin
		value.bin <= count_next;
		value.bcd <= calendar_pkg::to_bcd(count_next);
	end
end

endmodule

/* hw/time_display.sv */
`timescale 1ns/100ps
`include "calendar_params.svh"

module time_display (
	input logic clk,
	input logic reset,
	input logic [3:0] field_code,
	input calendar_pkg::field_value_t fields [`CAL_FIELDS],
	output calendar_pkg::date_time_t date_time,
	output calendar_pkg::bcd_pair_t selected
);

calendar_pkg::date_time_t date_time_next;
calendar_pkg::bcd_pair_t selected_next;

always_comb begin
	date_time_next.year = fields[`CAL_CODE_YEAR - 1].bcd;
	date_time_next.month = fields[`CAL_CODE_MONTH - 1].bcd;
	date_time_next.day = fields[`CAL_CODE_DAY - 1].bcd;
	date_time_next.hour = fields[`CAL_CODE_HOUR - 1].bcd;
	date_time_next.minute = fields[`CAL_CODE_MIN - 1].bcd;
	date_time_next.second = fields[`CAL_CODE_SEC - 1].bcd;
end

always_comb begin
	case (field_code)
		`CAL_CODE_SEC: selected_next = fields[`CAL_CODE_SEC - 1].bcd;
		`CAL_CODE_MIN: selected_next = fields[`CAL_CODE_MIN - 1].bcd;
		`CAL_CODE_HOUR: selected_next = fields[`CAL_CODE_HOUR - 1].bcd;
		`CAL_CODE_YEAR: selected_next = fields[`CAL_CODE_YEAR - 1].bcd;
		`CAL_CODE_MONTH: selected_next = fields[`CAL_CODE_MONTH - 1].bcd;
		`CAL_CODE_DAY: selected_next = fields[`CAL_CODE_DAY - 1].bcd;
		default: selected_next = '0;  // blank digits for a code with no field
	endcase
end

// the reset word mirrors the counters sitting at their lower limits
always_ff @(posedge clk or posedge reset) begin
	if (reset) begin
		date_time.year <= calendar_pkg::to_bcd(7'(`CAL_LOW_YEAR));
		date_time.month <= calendar_pkg::to_bcd(7'(`CAL_LOW_MONTH));
		date_time.day <= calendar_pkg::to_bcd(7'(`CAL_LOW_DAY));
		date_time.hour <= calendar_pkg::to_bcd(7'(`CAL_LOW_HOUR));
		date_time.minute <= calendar_pkg::to_bcd(7'(`CAL_LOW_MIN));
		date_time.second <= calendar_pkg::to_bcd(7'(`CAL_LOW_SEC));
		selected <= '0;
	end else begin
		date_time <= date_time_next;
		selected <= selected_next;
	end
end

endmodule

/* hw/calendar_set_top.sv */
`timescale 1ns/100ps
`include "calendar_params.svh"

module calendar_set_top (
	input logic clk,
	input logic reset,
	input logic [3:0] field_code,
	input logic btn_up,
	input logic btn_down,
	output calendar_pkg::date_time_t date_time,
	output calendar_pkg::bcd_pair_t selected
);

calendar_pkg::adjust_cmd_t cmd;
calendar_pkg::field_value_t fields [`CAL_FIELDS];

adjust_decoder adjust_decoder_i (
	.clk(clk),
	.reset(reset),
	.field_code(field_code),
	.btn_up(btn_up),
	.btn_down(btn_down),
	.cmd(cmd)
);

// counter k serves field code k + 1 so seconds come first and day last
generate
	for (genvar k = 0; k < `CAL_FIELDS; k++) begin : g_field
		field_counter #(
			.LOW(`CAL_LIMIT_LOW(k)),
			.HIGH(`CAL_LIMIT_HIGH(k))
		) field_counter_i (
			.clk(clk),
			.reset(reset),
			.up(cmd.up[k]),
			.down(cmd.down[k]),
			.value(fields[k])
		);
	end
endgenerate

time_display time_display_i (
	.clk(clk),
	.reset(reset),
	.field_code(field_code),
	.fields(fields),
	.date_time(date_time),
	.selected(selected)
);

endmodule

/* tb/calendar_set_tb.sv */
`timescale 1ns/100ps
`include "calendar_params.svh"

module calendar_set_tb;

localparam int PRESS_COUNT = 234;  // 32 day presses, 200 random ones, 2 in the held test
localparam int LONGEST_PRESS = 4 + 9;
localparam int TIMEOUT_CYCLES = PRESS_COUNT * LONGEST_PRESS + 300;

logic clk;
logic reset;
logic [3:0] field_code;
logic btn_up;
logic btn_down;
calendar_pkg::date_time_t date_time;
calendar_pkg::bcd_pair_t selected;

logic [31:0] lfsr_state;
int model_value [`CAL_FIELDS];
int low_limit [`CAL_FIELDS];
int high_limit [`CAL_FIELDS];
int check_count;
int error_count;

calendar_set_top calendar_set_top_i (
	.clk(clk),
	.reset(reset),
	.field_code(field_code),
	.btn_up(btn_up),
	.btn_down(btn_down),
	.date_time(date_time),
	.selected(selected)
);

initial begin
	clk = 1'b0;
	forever begin
		#50 clk = ~clk;
	end
end

// taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic feedback;
	feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], feedback};
endfunction

task automatic take_random(input int nbits, output int value);
	int i;
	value = 0;
	for (i = 0; i < nbits; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		value = (value << 1) | int'(lfsr_state[0]);
	end
endtask

function automatic logic [7:0] model_bcd(input int v);
	return {4'(v / 10), 4'(v % 10)};
endfunction

function automatic logic [7:0] expected_selected(input logic [3:0] code);
	if (code >= `CAL_CODE_SEC && code <= `CAL_CODE_DAY) begin
		return model_bcd(model_value[int'(code) - 1]);
	end
	return 8'd0;
endfunction

task automatic step_cycle();
	@(posedge clk);
	#10;  // inputs change and outputs are sampled here
endtask

task automatic check_value(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("FAIL t=%0t %s: got %h expected %h", $time, name, actual, expected);
	end
endtask

task automatic check_all_fields();
	check_value("date_time.year", date_time.year, model_bcd(model_value[`CAL_CODE_YEAR - 1]));
	check_value("date_time.month", date_time.month, model_bcd(model_value[`CAL_CODE_MONTH - 1]));
	check_value("date_time.day", date_time.day, model_bcd(model_value[`CAL_CODE_DAY - 1]));
	check_value("date_time.hour", date_time.hour, model_bcd(model_value[`CAL_CODE_HOUR - 1]));
	check_value("date_time.minute", date_time.minute, model_bcd(model_value[`CAL_CODE_MIN - 1]));
	check_value("date_time.second", date_time.second, model_bcd(model_value[`CAL_CODE_SEC - 1]));
endtask

// up wins when both buttons are pressed together
task automatic apply_model_step(input int idx, input logic up, input logic down);
	if (up) begin
		if (model_value[idx] == high_limit[idx]) begin
			model_value[idx] = low_limit[idx];
		end else begin
			model_value[idx] = model_value[idx] + 1;
		end
	end else if (down) begin
		if (model_value[idx] == low_limit[idx]) begin
			model_value[idx] = high_limit[idx];
		end else begin
			model_value[idx] = model_value[idx] - 1;
		end
	end
endtask

task automatic press_button(input logic [3:0] code, input logic up, input logic down,
		input int hold, input int gap);
	field_code = code;  // held steady until the gap is over
	btn_up = up;
	btn_down = down;
	repeat (hold) step_cycle();
	btn_up = 1'b0;
	btn_down = 1'b0;
	repeat (gap) step_cycle();
	if (code >= `CAL_CODE_SEC && code <= `CAL_CODE_DAY) begin
		apply_model_step(int'(code) - 1, up, down);
	end
endtask

initial begin
	repeat (TIMEOUT_CYCLES) @(posedge clk);
	$display("error: run timed out after %0t with the tests still running", $time);
	$display("TEST FAILED");
	$finish;
end

initial begin
	int k;
	int n;
	int code_r;
	int dir_r;
	int hold_r;
	int gap_r;
	int errors_before;
	reset = 1'b1;
	field_code = 4'd0;
	btn_up = 1'b0;
	btn_down = 1'b0;
	lfsr_state = 32'hd554;
	check_count = 0;
	error_count = 0;
	for (k = 0; k < `CAL_FIELDS; k++) begin
		low_limit[k] = `CAL_LIMIT_LOW(k);
		high_limit[k] = `CAL_LIMIT_HIGH(k);
		model_value[k] = low_limit[k];
	end
	repeat (4) @(posedge clk);
	#10;
	reset = 1'b0;
	step_cycle();

	errors_before = error_count;
	check_all_fields();
	check_value("selected", selected, 8'd0);
	$display("test 1 reset values done, %0d errors", error_count - errors_before);

	errors_before = error_count;
	for (n = 0; n < 31; n++) begin
		press_button(`CAL_CODE_DAY, 1'b1, 1'b0, 1, 6);
		check_value("date_time.day", date_time.day, model_bcd(model_value[`CAL_CODE_DAY - 1]));
	end
	press_button(`CAL_CODE_DAY, 1'b0, 1'b1, 1, 6);  // wraps from 01 back to 31
	check_value("date_time.day", date_time.day, model_bcd(model_value[`CAL_CODE_DAY - 1]));
	$display("test 2 day walk done, %0d errors", error_count - errors_before);

	errors_before = error_count;
	for (n = 0; n < 200; n++) begin
		take_random(4, code_r);
		take_random(1, dir_r);
		take_random(2, hold_r);
		take_random(2, gap_r);
		press_button(4'(code_r), dir_r == 1, dir_r == 0, hold_r + 1, gap_r + 6);
		check_all_fields();
	end
	$display("test 3 random presses done, %0d errors", error_count - errors_before);

	errors_before = error_count;
	press_button(`CAL_CODE_MIN, 1'b1, 1'b0, 12, 8);  // a long hold still gives a single step
	check_all_fields();
	press_button(`CAL_CODE_HOUR, 1'b1, 1'b1, 2, 8);
	check_all_fields();
	$display("test 4 held and double presses done, %0d errors", error_count - errors_before);

	errors_before = error_count;
	for (n = 0; n < 16; n++) begin
		field_code = 4'(n);
		step_cycle();
		check_value("selected", selected, expected_selected(4'(n)));
	end
	$display("test 5 selected field done, %0d errors", error_count - errors_before);

	$display("summary: 5 tests, %0d checks, %0d errors", check_count, error_count);
	if (error_count == 0) begin
		$display("TEST OK");
	end else begin
		$display("TEST FAILED");
	end
	$finish;
end

endmodule

/* sim.f */
+incdir+include
hw/calendar_pkg.sv
hw/adjust_decoder.sv
hw/field_counter.sv
hw/time_display.sv
hw/calendar_set_top.sv
tb/calendar_set_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = calendar_set_tb
FILELIST = sim.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
